/* dualIsaDecode.f */
+incdir+tests
logic/dualIsaPkg.sv
logic/rvDecoder.sv
logic/armDecoder.sv
logic/isaSelect.sv
logic/operandExtract.sv
logic/decodeExecReg.sv
logic/dualIsaDecode.sv
tests/tbDualIsaDecode.sv

/* logic/armDecoder.sv */
module armDecoder import dualIsaPkg::*; (
  input  instrWord   instr,
  output logic       legal,
  output logic       regWrite,
  output logic       memWrite,
  output logic       aluSrc,
  output logic       branch,
  output logic       memToReg,
  output logic       pcSrc,
  output logic [1:0] flagWrite,
  output logic [1:0] regSrc,
  output logic [2:0] immSrc,
  output logic [3:0] aluControl
);

  logic [10:0] controls;
  logic        aluOp;
  logic        condOk;
  logic        mainOk;
  logic        aluOk;
  logic        arith;

  assign condOk = (instr.arm.cond != 4'b1111);  // unconditional space not supported

  always_comb begin
    mainOk = 1'b1;
    // regSrc immSrc aluSrc memToReg regWrite memWrite branch aluOp
    case (instr.arm.op)
      armOpDp: begin
        if (instr.arm.funct[5])
          controls = {2'b00, immArm8, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};  // rotated imm
        else
          controls = {2'b00, immArm8, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};  // register form
      end
      armOpMem: begin
        if (instr.arm.funct[0])
          controls = {2'b00, immArm12, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};  // LDR
        else
          controls = {2'b10, immArm12, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};  // STR reads rd
        mainOk = !instr.arm.funct[5] && !instr.arm.funct[2];  // imm offset, word size
      end
      armOpBranch: begin
        controls = {2'b01, immArm24, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};  // base is PC
        mainOk   = (instr.arm.funct[5:4] == 2'b10);  // B without link
      end
      default: begin
        controls = '0;
        mainOk   = 1'b0;
      end
    endcase
  end

  assign {regSrc, immSrc, aluSrc, memToReg, regWrite, memWrite, branch, aluOp} = controls;

  always_comb begin
    aluOk      = 1'b1;
    arith      = 1'b0;
    aluControl = aluAdd;  // address math for LDR, STR and B
    flagWrite  = 2'b00;
    if (aluOp) begin
      case (instr.arm.funct[4:1])
        4'b0100: begin
          aluControl = aluAdd;
          arith      = 1'b1;
        end
        4'b0010: begin
          aluControl = aluSub;
          arith      = 1'b1;
        end
        4'b0000: aluControl = aluAnd;
        4'b1100: aluControl = aluOr;
        default: aluOk = 1'b0;
      endcase
      flagWrite[1] = instr.arm.funct[0];          // N and Z on any S
      flagWrite[0] = instr.arm.funct[0] & arith;  // C and V for add/sub
    end
  end

  assign pcSrc = (instr.arm.rd == pcRegAddr) & regWrite;
  assign legal = condOk & mainOk & aluOk;

endmodule

/* logic/decodeExecReg.sv */
module decodeExecReg (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stall,
  input  logic        issue,
  input  logic        illegal,
  input  logic        armMode,
  input  logic        regWrite,
  input  logic        memWrite,
  input  logic        aluSrc,
  input  logic        branch,
  input  logic        jump,
  input  logic        pcRel,
  input  logic        pcSrc,
  input  logic [1:0]  resultSrc,
  input  logic [1:0]  flagWrite,
  input  logic [1:0]  regSrc,
  input  logic [2:0]  immSrc,
  input  logic [3:0]  aluControl,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic [31:0] immExt,
  output logic        illegalE,
  output logic        armModeE,
  output logic        regWriteE,
  output logic        memWriteE,
  output logic        aluSrcE,
  output logic        branchE,
  output logic        jumpE,
  output logic        pcRelE,
  output logic        pcSrcE,
  output logic [1:0]  resultSrcE,
  output logic [1:0]  flagWriteE,
  output logic [1:0]  regSrcE,
  output logic [2:0]  immSrcE,
  output logic [3:0]  aluControlE,
  output logic [4:0]  ra1E,
  output logic [4:0]  ra2E,
  output logic [4:0]  waE,
  output logic [31:0] immExtE
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {illegalE, armModeE, regWriteE, memWriteE, aluSrcE, branchE} <= '0;
      {jumpE, pcRelE, pcSrcE, resultSrcE, flagWriteE} <= '0;
      {regSrcE, immSrcE, aluControlE} <= '0;
    end else if (!stall) begin
      illegalE    <= illegal;
      armModeE    <= armMode;
      regWriteE   <= regWrite & issue;  // state-changing controls drop to a bubble
      memWriteE   <= memWrite & issue;
      branchE     <= branch & issue;
      jumpE       <= jump & issue;
      pcSrcE      <= pcSrc & issue;
      flagWriteE  <= issue ? flagWrite : 2'b00;
      aluSrcE     <= aluSrc;
      pcRelE      <= pcRel;
      resultSrcE  <= resultSrc;
      regSrcE     <= regSrc;
      immSrcE     <= immSrc;
      aluControlE <= aluControl;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ra1E    <= ra1;
      ra2E    <= ra2;
      waE     <= wa;
      immExtE <= immExt;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !(memWriteE && regWriteE))
    else $error("decodeExecReg: store also writes a register");

endmodule

/* logic/dualIsaDecode.sv */
module dualIsaDecode (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instr,
  input  logic        instrValid,
  input  logic        flush,
  input  logic        stall,
  output logic        illegalE,
  output logic        armModeE,
  output logic        regWriteE,
  output logic        memWriteE,
  output logic        aluSrcE,
  output logic        branchE,
  output logic        jumpE,
  output logic        pcRelE,
  output logic        pcSrcE,
  output logic [1:0]  resultSrcE,
  output logic [1:0]  flagWriteE,
  output logic [1:0]  regSrcE,
  output logic [2:0]  immSrcE,
  output logic [3:0]  aluControlE,
  output logic [4:0]  ra1E,
  output logic [4:0]  ra2E,
  output logic [4:0]  waE,
  output logic [31:0] immExtE
);

  logic       rvLegal, rvRegWrite, rvMemWrite, rvAluSrc, rvBranch, rvJump, rvPcRel;
  logic [1:0] rvResultSrc;
  logic [2:0] rvImmSrc;
  logic [3:0] rvAluControl;

  logic       armLegal, armRegWrite, armMemWrite, armAluSrc, armBranch;
  logic       armMemToReg, armPcSrc;
  logic [1:0] armFlagWrite, armRegSrc;
  logic [2:0] armImmSrc;
  logic [3:0] armAluControl;

  logic        armMode, issue, illegal;
  logic        regWrite, memWrite, aluSrc, branch, jump, pcRel, pcSrc;
  logic [1:0]  resultSrc, flagWrite, regSrc;
  logic [2:0]  immSrc;
  logic [3:0]  aluControl;
  logic [4:0]  ra1, ra2, wa;
  logic [31:0] immExt;

  rvDecoder i_rvDecoder (
    .instr(instr), .legal(rvLegal), .regWrite(rvRegWrite), .memWrite(rvMemWrite),
    .aluSrc(rvAluSrc), .branch(rvBranch), .jump(rvJump), .pcRel(rvPcRel),
    .resultSrc(rvResultSrc), .immSrc(rvImmSrc), .aluControl(rvAluControl)
  );

  armDecoder i_armDecoder (
    .instr(instr), .legal(armLegal), .regWrite(armRegWrite), .memWrite(armMemWrite),
    .aluSrc(armAluSrc), .branch(armBranch), .memToReg(armMemToReg), .pcSrc(armPcSrc),
    .flagWrite(armFlagWrite), .regSrc(armRegSrc), .immSrc(armImmSrc),
    .aluControl(armAluControl)
  );

  isaSelect i_isaSelect (.*);  // both bundles arrive under their own prefixes

  operandExtract i_operandExtract (.*);

  decodeExecReg i_decodeExecReg (.*);

endmodule

/* logic/dualIsaPkg.sv */
package dualIsaPkg;

  // one fetched word, read as RV32I or as ARMv4
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rv;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic [5:0]  funct;  // I, cmd/PUBWL, S
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] src2;
    } arm;
  } instrWord;

  // RV32I major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opRtype  = 7'b0110011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opItype  = 7'b0010011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;

  // ARM op field, bits 27:26
  localparam logic [1:0] armOpDp     = 2'b00;
  localparam logic [1:0] armOpMem    = 2'b01;
  localparam logic [1:0] armOpBranch = 2'b10;

  // ALU control, common to both ISAs
  localparam logic [3:0] aluAdd = 4'b0000;
  localparam logic [3:0] aluSub = 4'b0001;
  localparam logic [3:0] aluAnd = 4'b0010;
  localparam logic [3:0] aluOr  = 4'b0011;
  localparam logic [3:0] aluXor = 4'b0100;
  localparam logic [3:0] aluSlt = 4'b0101;

  // immediate formats, RISC-V codes below the ARM ones
  localparam logic [2:0] immRvI   = 3'd0;
  localparam logic [2:0] immRvS   = 3'd1;
  localparam logic [2:0] immRvB   = 3'd2;
  localparam logic [2:0] immRvJ   = 3'd3;
  localparam logic [2:0] immRvU   = 3'd4;
  localparam logic [2:0] immArm8  = 3'd5;
  localparam logic [2:0] immArm12 = 3'd6;
  localparam logic [2:0] immArm24 = 3'd7;

  // writeback source
  localparam logic [1:0] resAlu     = 2'd0;
  localparam logic [1:0] resMem     = 2'd1;
  localparam logic [1:0] resPcPlus4 = 2'd2;

  localparam logic [3:0] pcRegAddr   = 4'd15;  // r15 is the ARM PC
  localparam logic [1:0] memSizeWord = 2'd2;   // log2 of 4 bytes

endpackage

/* logic/isaSelect.sv */
module isaSelect import dualIsaPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       instrValid,
  input  logic       flush,
  input  logic       stall,
  input  logic       rvLegal,
  input  logic       rvRegWrite,
  input  logic       rvMemWrite,
  input  logic       rvAluSrc,
  input  logic       rvBranch,
  input  logic       rvJump,
  input  logic       rvPcRel,
  input  logic [1:0] rvResultSrc,
  input  logic [2:0] rvImmSrc,
  input  logic [3:0] rvAluControl,
  input  logic       armLegal,
  input  logic       armRegWrite,
  input  logic       armMemWrite,
  input  logic       armAluSrc,
  input  logic       armBranch,
  input  logic       armMemToReg,
  input  logic       armPcSrc,
  input  logic [1:0] armFlagWrite,
  input  logic [1:0] armRegSrc,
  input  logic [2:0] armImmSrc,
  input  logic [3:0] armAluControl,
  output logic       armMode,
  output logic       issue,
  output logic       illegal,
  output logic       regWrite,
  output logic       memWrite,
  output logic       aluSrc,
  output logic       branch,
  output logic       jump,
  output logic       pcRel,
  output logic       pcSrc,
  output logic [1:0] resultSrc,
  output logic [1:0] flagWrite,
  output logic [1:0] regSrc,
  output logic [2:0] immSrc,
  output logic [3:0] aluControl
);

  logic modeQ;       // ISA of the last accepted word
  logic decodeLive;

  assign decodeLive = instrValid & ~flush;

  // a word legal in one ISA only picks that ISA, otherwise the mode stays
  always_comb begin
    armMode = modeQ;
    if (decodeLive) begin
      case ({rvLegal, armLegal})
        2'b10:   armMode = 1'b0;
        2'b01:   armMode = 1'b1;
        default: armMode = modeQ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      modeQ <= 1'b0;  // start in RISC-V
    else if (instrValid && !stall)
      modeQ <= armMode;
  end

  assign issue   = decodeLive & (rvLegal | armLegal);
  assign illegal = decodeLive & ~rvLegal & ~armLegal;

  always_comb begin
    if (armMode) begin
      regWrite   = armRegWrite;
      memWrite   = armMemWrite;
      aluSrc     = armAluSrc;
      branch     = armBranch;
      jump       = 1'b0;
      pcRel      = 1'b0;
      pcSrc      = armPcSrc;
      resultSrc  = armMemToReg ? resMem : resAlu;  // no link result in the subset
      flagWrite  = armFlagWrite;
      regSrc     = armRegSrc;
      immSrc     = armImmSrc;
      aluControl = armAluControl;
    end else begin
      regWrite   = rvRegWrite;
      memWrite   = rvMemWrite;
      aluSrc     = rvAluSrc;
      branch     = rvBranch;
      jump       = rvJump;
      pcRel      = rvPcRel;
      pcSrc      = 1'b0;
      resultSrc  = rvResultSrc;
      flagWrite  = 2'b00;  // RISC-V has no flags
      regSrc     = 2'b00;
      immSrc     = rvImmSrc;
      aluControl = rvAluControl;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !$isunknown(armMode))
    else $error("isaSelect: ISA mode unknown");

  assert property (@(posedge clk) disable iff (!rstN)
                   issue |-> (armMode ? armLegal : rvLegal))
    else $error("isaSelect: issued word not legal in the chosen ISA");

endmodule

/* logic/operandExtract.sv */
module operandExtract import dualIsaPkg::*; (
  input  instrWord    instr,
  input  logic [2:0]  immSrc,
  input  logic [1:0]  regSrc,
  output logic [4:0]  ra1,
  output logic [4:0]  ra2,
  output logic [4:0]  wa,
  output logic [31:0] immExt
);

  logic armFormat;

  // the format codes already tell the two ISAs apart
  assign armFormat = immSrc inside {immArm8, immArm12, immArm24};

  always_comb begin
    case (immSrc)
      immRvI:   immExt = {{20{instr[31]}}, instr.rv.funct7, instr.rv.rs2};
      immRvS:   immExt = {{20{instr[31]}}, instr.rv.funct7, instr.rv.rd};
      immRvB:   immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      immRvJ:   immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      immRvU:   immExt = {instr[31:12], 12'b0};
      immArm8:  immExt = {24'b0, instr.arm.src2[7:0]};  // rotate field ignored
      immArm12: immExt = {20'b0, instr.arm.src2};
      immArm24: immExt = {{6{instr[23]}}, instr[23:0], 2'b00};  // word offset to bytes
      default:  immExt = 32'b0;
    endcase
  end

  always_comb begin
    if (armFormat) begin
      ra1 = {1'b0, regSrc[0] ? pcRegAddr : instr.arm.rn};
      ra2 = {1'b0, regSrc[1] ? instr.arm.rd : instr.arm.src2[3:0]};  // STR data from rd
      wa  = {1'b0, instr.arm.rd};
    end else begin
      ra1 = instr.rv.rs1;
      ra2 = instr.rv.rs2;
      wa  = instr.rv.rd;
    end
  end

endmodule

/* logic/rvDecoder.sv */
module rvDecoder import dualIsaPkg::*; (
  input  instrWord   instr,
  output logic       legal,
  output logic       regWrite,
  output logic       memWrite,
  output logic       aluSrc,
  output logic       branch,
  output logic       jump,
  output logic       pcRel,
  output logic [1:0] resultSrc,
  output logic [2:0] immSrc,
  output logic [3:0] aluControl
);

  logic [12:0] controls;
  logic [1:0]  aluOp;
  logic        mainOk;
  logic        funct3Ok;
  logic        aluOk;
  logic        rtypeSub;
  logic        listedWord;

  assign rtypeSub = instr.rv.opcode[5] & instr.rv.funct7[5];  // R-type only, never subi

  always_comb begin
    mainOk   = 1'b1;
    funct3Ok = 1'b1;
    // regWrite immSrc aluSrc memWrite resultSrc branch aluOp jump pcRel
    case (instr.rv.opcode)
      opLoad: begin
        controls = {1'b1, immRvI, 1'b1, 1'b0, resMem, 1'b0, 2'b00, 1'b0, 1'b0};
        funct3Ok = (instr.rv.funct3 == {1'b0, memSizeWord});  // lw only
      end
      opStore: begin
        controls = {1'b0, immRvS, 1'b1, 1'b1, resAlu, 1'b0, 2'b00, 1'b0, 1'b0};
        funct3Ok = (instr.rv.funct3 == {1'b0, memSizeWord});  // sw only
      end
      opRtype:  controls = {1'b1, immRvI, 1'b0, 1'b0, resAlu, 1'b0, 2'b10, 1'b0, 1'b0};
      opItype:  controls = {1'b1, immRvI, 1'b1, 1'b0, resAlu, 1'b0, 2'b10, 1'b0, 1'b0};
      opBranch: begin
        controls = {1'b0, immRvB, 1'b0, 1'b0, resAlu, 1'b1, 2'b01, 1'b0, 1'b0};
        funct3Ok = (instr.rv.funct3 == 3'b000);  // beq only
      end
      opJal:    controls = {1'b1, immRvJ, 1'b0, 1'b0, resPcPlus4, 1'b0, 2'b00, 1'b1, 1'b0};
      opLui:    controls = {1'b1, immRvU, 1'b1, 1'b0, resAlu, 1'b0, 2'b00, 1'b0, 1'b0};
      opAuipc:  controls = {1'b1, immRvU, 1'b1, 1'b0, resAlu, 1'b0, 2'b00, 1'b0, 1'b1};
      default: begin
        controls = '0;
        mainOk   = 1'b0;
      end
    endcase
  end

  assign {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump, pcRel} = controls;

  always_comb begin
    aluOk = 1'b1;
    case (aluOp)
      2'b00: aluControl = aluAdd;  // address and upper-immediate math
      2'b01: aluControl = aluSub;  // beq compare
      default: begin
        case (instr.rv.funct3)
          3'b000:  aluControl = rtypeSub ? aluSub : aluAdd;
          3'b010:  aluControl = aluSlt;
          3'b100:  aluControl = aluXor;
          3'b110:  aluControl = aluOr;
          3'b111:  aluControl = aluAnd;
          default: begin
            aluControl = aluAdd;
            aluOk      = 1'b0;  // shifts and sltu are not in the subset
          end
        endcase
      end
    endcase
  end

  assign legal = mainOk & funct3Ok & aluOk;

  // independent list of the supported subset, checked against the tables above
  always_comb begin
    case (instr.rv.opcode)
      opLoad, opStore:  listedWord = (instr.rv.funct3 == 3'b010);
      opRtype, opItype: listedWord = instr.rv.funct3 inside {3'b000, 3'b010, 3'b100,
                                                              3'b110, 3'b111};
      opBranch:         listedWord = (instr.rv.funct3 == 3'b000);
      opJal, opLui, opAuipc: listedWord = 1'b1;
      default:          listedWord = 1'b0;
    endcase
    assert final (!listedWord || legal)
      else $error("rvDecoder: supported word %h flagged illegal", instr);
  end

endmodule

/* tests/decodeVectors.svh */
// columns: group, instr, instrValid, flush, then expected regWriteE, memWriteE, branchE,
// aluControlE, immExtE, waE, flagWriteE, pcSrcE, armModeE, illegalE
// second line of a row: expected jumpE, aluSrcE, pcRelE, resultSrcE, regSrcE, immSrcE, ra1E, ra2E
// groups: 1 RISC-V decode, 2 mode switching, 3 ARM decode, 4 flush and illegal

task automatic loadVectors;
  // mode starts at 0, every word here is legal RISC-V
  addRow(1, 32'hFFD30293, 1, 0, 1, 0, 0, aluAdd, 32'hFFFFFFFD, 5,  0, 0, 0, 0,  // addi x5,x6,-3
         0, 1, 0, resAlu, 0, immRvI, 6, 29);
  addRow(1, 32'h409403B3, 1, 0, 1, 0, 0, aluSub, 32'h00000409, 7,  0, 0, 0, 0,  // sub, also ARM
         0, 0, 0, resAlu, 0, immRvI, 8, 9);
  addRow(1, 32'h00C5A533, 1, 0, 1, 0, 0, aluSlt, 32'h0000000C, 10, 0, 0, 0, 0,  // slt x10
         0, 0, 0, resAlu, 0, immRvI, 11, 12);
  addRow(1, 32'h12314093, 1, 0, 1, 0, 0, aluXor, 32'h00000123, 1,  0, 0, 0, 0,  // xori x1
         0, 1, 0, resAlu, 0, immRvI, 2, 3);
  addRow(1, 32'hFFF27193, 1, 0, 1, 0, 0, aluAnd, 32'hFFFFFFFF, 3,  0, 0, 0, 0,  // andi x3,x4,-1
         0, 1, 0, resAlu, 0, immRvI, 4, 31);
  addRow(1, 32'h00F766B3, 1, 0, 1, 0, 0, aluOr,  32'h0000000F, 13, 0, 0, 0, 0,  // or x13
         0, 0, 0, resAlu, 0, immRvI, 14, 15);
  addRow(1, 32'h01012403, 1, 0, 1, 0, 0, aluAdd, 32'h00000010, 8,  0, 0, 0, 0,  // lw x8,16(x2)
         0, 1, 0, resMem, 0, immRvI, 2, 16);
  addRow(1, 32'hFE912C23, 1, 0, 0, 1, 0, aluAdd, 32'hFFFFFFF8, 24, 0, 0, 0, 0,  // sw x9,-8(x2)
         0, 1, 0, resAlu, 0, immRvS, 2, 9);
  addRow(1, 32'hFE2088E3, 1, 0, 0, 0, 1, aluSub, 32'hFFFFFFF0, 17, 0, 0, 0, 0,  // beq -16
         0, 0, 0, resAlu, 0, immRvB, 1, 2);
  addRow(1, 32'h801FF0EF, 1, 0, 1, 0, 0, aluAdd, 32'hFFFFF800, 1,  0, 0, 0, 0,  // jal -2048
         1, 0, 0, resPcPlus4, 0, immRvJ, 31, 1);
  addRow(1, 32'h12345A37, 1, 0, 1, 0, 0, aluAdd, 32'h12345000, 20, 0, 0, 0, 0,  // lui x20
         0, 1, 0, resAlu, 0, immRvU, 8, 3);
  addRow(1, 32'hFFFFFA97, 1, 0, 1, 0, 0, aluAdd, 32'hFFFFF000, 21, 0, 0, 0, 0,  // auipc x21
         0, 1, 1, resAlu, 0, immRvU, 31, 31);

  // ARM-only word, then a word legal in both, then RISC-V-only
  addRow(2, 32'hE2921005, 1, 0, 1, 0, 0, aluAdd, 32'h00000005, 1,  3, 0, 1, 0,  // ADDS r1,r2,#5
         0, 1, 0, resAlu, 0, immArm8, 2, 5);
  addRow(2, 32'h409403B3, 1, 0, 1, 0, 0, aluAdd, 32'h000000B3, 0,  3, 0, 1, 0,  // read as ADDS
         0, 0, 0, resAlu, 0, immArm8, 4, 3);
  addRow(2, 32'hFFD30293, 1, 0, 1, 0, 0, aluAdd, 32'hFFFFFFFD, 5,  0, 0, 0, 0,  // addi, back to RV
         0, 1, 0, resAlu, 0, immRvI, 6, 29);

  // ARM data processing, memory and branch
  addRow(3, 32'hE0443005, 1, 0, 1, 0, 0, aluSub, 32'h00000005, 3,  0, 0, 1, 0,  // SUB r3,r4,r5
         0, 0, 0, resAlu, 0, immArm8, 4, 5);
  addRow(3, 32'hE21760FF, 1, 0, 1, 0, 0, aluAnd, 32'h000000FF, 6,  2, 0, 1, 0,  // ANDS only NZ
         0, 1, 0, resAlu, 0, immArm8, 7, 15);
  addRow(3, 32'hE180F001, 1, 0, 1, 0, 0, aluOr,  32'h00000001, 15, 0, 1, 1, 0,  // ORR pc,r0,r1
         0, 0, 0, resAlu, 0, immArm8, 0, 1);
  addRow(3, 32'hE5932010, 1, 0, 1, 0, 0, aluAdd, 32'h00000010, 2,  0, 0, 1, 0,  // LDR r2,[r3,#16]
         0, 1, 0, resMem, 0, immArm12, 3, 0);
  addRow(3, 32'hE5854008, 1, 0, 0, 1, 0, aluAdd, 32'h00000008, 4,  0, 0, 1, 0,  // STR r4,[r5,#8]
         0, 1, 0, resAlu, 2, immArm12, 5, 4);
  addRow(3, 32'hEAFFFFFC, 1, 0, 0, 0, 1, aluAdd, 32'hFFFFFFF0, 15, 0, 0, 1, 0,  // B -4 words
         0, 1, 0, resAlu, 1, immArm24, 15, 12);

  // bubbles in ARM mode, then in RISC-V mode
  addRow(4, 32'hFFD30293, 1, 1, 0, 0, 0, aluAdd, 32'hFFFFFFFD, 5,  0, 0, 1, 0,  // flushed addi
         0, 0, 0, resAlu, 0, immRvI, 6, 29);
  addRow(4, 32'hFFFFFFFF, 1, 0, 0, 0, 0, aluAdd, 32'hFFFFFFFF, 31, 0, 0, 1, 1,  // legal nowhere
         0, 0, 0, resAlu, 0, immRvI, 31, 31);
  addRow(4, 32'hFFD30293, 0, 0, 0, 0, 0, aluAdd, 32'hFFFFFFFD, 5,  0, 0, 1, 0,  // not valid
         0, 0, 0, resAlu, 0, immRvI, 6, 29);
  addRow(4, 32'hFFD30293, 1, 0, 1, 0, 0, aluAdd, 32'hFFFFFFFD, 5,  0, 0, 0, 0,  // addi issues
         0, 1, 0, resAlu, 0, immRvI, 6, 29);
  addRow(4, 32'hE2921005, 1, 1, 0, 0, 0, aluAdd, 32'hFFFFFE29, 0,  0, 0, 0, 0,  // flushed ADDS
         0, 0, 0, resAlu, 0, immRvI, 4, 9);
  addRow(4, 32'hFFFFFFFF, 1, 0, 0, 0, 0, aluAdd, 32'hFFFFFFFF, 31, 0, 0, 0, 1,  // legal nowhere
         0, 0, 0, resAlu, 0, immRvI, 31, 31);
endtask

/* tests/tbDualIsaDecode.sv */
module tbDualIsaDecode import dualIsaPkg::*; ();

  typedef struct packed {
    logic [2:0]  group;
    instrWord    instr;
    logic        valid;
    logic        flush;
    logic        regWrite;
    logic        memWrite;
    logic        branch;
    logic [3:0]  aluControl;
    logic [31:0] immExt;
    logic [4:0]  wa;
    logic [1:0]  flagWrite;
    logic        pcSrc;
    logic        armMode;
    logic        illegal;
    logic        jump;
    logic        aluSrc;
    logic        pcRel;
    logic [1:0]  resultSrc;
    logic [1:0]  regSrc;
    logic [2:0]  immSrc;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
  } vecRow;

  logic        clk;
  logic        rstN;
  instrWord    instr;
  logic        instrValid;
  logic        flush;
  logic        stall;
  logic        illegalE, armModeE, regWriteE, memWriteE, aluSrcE, branchE;
  logic        jumpE, pcRelE, pcSrcE;
  logic [1:0]  resultSrcE, flagWriteE, regSrcE;
  logic [2:0]  immSrcE;
  logic [3:0]  aluControlE;
  logic [4:0]  ra1E, ra2E, waE;
  logic [31:0] immExtE;

  vecRow rows[$];
  vecRow lastExp;  // what the E stage holds while stalled
  string groupName [5] = '{"reset", "RISC-V decode", "mode switching", "ARM decode",
                           "flush and illegal"};
  int    checkCount, errorCount, groupRows, groupErrors, stallCycles, stallErrors;
  int    errorsBefore, burst;

  dualIsaDecode i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic void addRow(int group, logic [31:0] word, logic valid, logic fl,
                                 logic rw, logic mw, logic br, logic [3:0] alu,
                                 logic [31:0] imm, logic [4:0] wa, logic [1:0] fw,
                                 logic pc, logic am, logic il, logic jmp, logic asrc,
                                 logic prel, logic [1:0] res, logic [1:0] rsrc,
                                 logic [2:0] isrc, logic [4:0] r1, logic [4:0] r2);
    vecRow r;
    r = {group[2:0], word, valid, fl, rw, mw, br, alu, imm, wa, fw, pc, am, il,
         jmp, asrc, prel, res, rsrc, isrc, r1, r2};
    rows.push_back(r);
  endfunction

  `include "decodeVectors.svh"

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERROR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic compareOutputs(vecRow e);
    checkValue("regWriteE", regWriteE, e.regWrite);
    checkValue("memWriteE", memWriteE, e.memWrite);
    checkValue("branchE", branchE, e.branch);
    checkValue("aluControlE", aluControlE, e.aluControl);
    checkValue("immExtE", immExtE, e.immExt);
    checkValue("waE", waE, e.wa);
    checkValue("flagWriteE", flagWriteE, e.flagWrite);
    checkValue("pcSrcE", pcSrcE, e.pcSrc);
    checkValue("armModeE", armModeE, e.armMode);
    checkValue("illegalE", illegalE, e.illegal);
    checkValue("jumpE", jumpE, e.jump);
    checkValue("aluSrcE", aluSrcE, e.aluSrc);
    checkValue("pcRelE", pcRelE, e.pcRel);
    checkValue("resultSrcE", resultSrcE, e.resultSrc);
    checkValue("regSrcE", regSrcE, e.regSrc);
    checkValue("immSrcE", immSrcE, e.immSrc);
    checkValue("ra1E", ra1E, e.ra1);
    checkValue("ra2E", ra2E, e.ra2);
  endtask

  task automatic driveInputs(vecRow r, logic st);
    instr      = r.instr;
    instrValid = r.valid;
    flush      = r.flush;
    stall      = st;
  endtask

  // polls off the clock edges, returns 5 units after the next rising edge
  task automatic nextEdge;
    int steps;
    steps = 0;
    while (clk !== 1'b0 && steps < 20) begin
      #10;
      steps++;
    end
    while (clk !== 1'b1 && steps < 20) begin
      #10;
      steps++;
    end
    if (steps >= 20) begin
      $display("timeout: no rising clock edge within %0d time units", steps * 10);
      $display(">>> FAIL");
      $finish;
    end
  endtask

  initial begin
    int idx;
    void'($urandom(75));
    rstN       = 1'b0;
    instr      = '0;
    instrValid = 1'b0;
    flush      = 1'b0;
    stall      = 1'b0;
    loadVectors();
    #5;
    repeat (3) nextEdge();
    rstN = 1'b1;
    checkValue("regWriteE", regWriteE, 0);
    checkValue("memWriteE", memWriteE, 0);
    checkValue("branchE", branchE, 0);
    checkValue("jumpE", jumpE, 0);
    checkValue("pcSrcE", pcSrcE, 0);
    checkValue("flagWriteE", flagWriteE, 0);
    checkValue("armModeE", armModeE, 0);
    checkValue("illegalE", illegalE, 0);
    $display("%s: %0d checks, %0d mismatches", groupName[0], checkCount, errorCount);
    for (idx = 0; idx < rows.size(); idx++) begin
      burst = 0;
      while (idx > 0 && burst < 3 && $urandom % 4 == 0) begin  // next word waits behind stall
        driveInputs(rows[idx], 1'b1);
        nextEdge();
        errorsBefore = errorCount;
        compareOutputs(lastExp);
        stallErrors += errorCount - errorsBefore;
        stallCycles++;
        burst++;
      end
      driveInputs(rows[idx], 1'b0);
      nextEdge();
      errorsBefore = errorCount;
      compareOutputs(rows[idx]);
      groupErrors += errorCount - errorsBefore;
      groupRows++;
      lastExp = rows[idx];
      if (idx == rows.size() - 1 || rows[idx + 1].group != rows[idx].group) begin
        $display("%s: %0d rows, %0d mismatches", groupName[rows[idx].group], groupRows,
                 groupErrors);
        groupRows   = 0;
        groupErrors = 0;
      end
    end
    $display("stall: %0d stalled cycles, %0d mismatches", stallCycles, stallErrors);
    $display("total: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
